//--- stm_trace.f
hdl/rv_trace_pkg.sv
hdl/stm_dbg_pkg.sv
hdl/stm_trace_tap.sv
hdl/stm_event_queue.sv
hdl/stm_pkt_builder.sv
hdl/stm_ctrl_regs.sv
hdl/stm_top.sv
dv/stm_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := stm_trace.f
TB_TOP     := stm_tb
RTL_TOP    := stm_top
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary -j 0
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/stm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stm_tb;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam logic [15:0] CORE_ID    = 16'h0010;
  localparam int          TIMEOUT    = 2000;       // Cycles per wait
  localparam logic [31:0] SEED       = 32'heccb;
  localparam int          NO_LIMIT   = 1 << 30;

  logic                    clk;
  logic                    arst_n;
  rv_trace_pkg::rv_trace_t trace;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [1:0]              wb_adr;
  logic [31:0]             wb_dat_i;
  logic [31:0]             wb_dat_o;
  logic                    wb_ack;
  stm_dbg_pkg::dbg_flit_t  debug_out;
  logic                    debug_out_ready;

  // Reference model state
  logic [31:0]               cyc_cnt;              // Cycles since reset release
  logic [31:0]               trace_rnd;
  logic [31:0]               ready_rnd;
  logic [31:0]               model_x3;
  logic [15:0]               model_dest;
  logic                      model_en;
  int                        room;                 // Accepts left before drops
  int                        exp_drops;
  logic [1:0]                ready_mode;           // 0 high, 1 random, 2 low
  stm_dbg_pkg::stm_stamped_t exp_q[$];             // Expected packets in order
  logic [31:0]               exp_start[$];         // Cycle flit 0 shows up
  logic                      exp_timed[$];         // Path idle at the marker
  int                        errors;
  int                        checks;
  int                        pkt_count;
  int                        pkt_seen;             // Last flits taken off the link
  int                        flit_idx;
  logic                      seen0;
  logic                      hold_chk;
  stm_dbg_pkg::dbg_flit_t    held;

  stm_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CORE_ID    (CORE_ID)
  ) UUT (
    .clk             (clk),
    .arst_n          (arst_n),
    .trace           (trace),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack          (wb_ack),
    .debug_out       (debug_out),
    .debug_out_ready (debug_out_ready)
  );

  always #5 clk = ~clk;                            // 10 ns period

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cyc_cnt <= '0;
    end else begin
      cyc_cnt <= cyc_cnt + 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random beat, about one marker in six, x3 written often
  function automatic rv_trace_pkg::rv_trace_t make_beat(input logic [31:0] r1,
                                                        input logic [31:0] r2);
    rv_trace_pkg::rv_trace_t b;
    b.valid = r1[0] | r1[1];
    b.insn  = {r1[31:16], r2[15:0]};
    if ((r1[15:8] % 8'd6) == 8'd0) begin
      b.valid          = 1'b1;
      b.insn[31:16]    = rv_trace_pkg::MARKER_HI;
      if (r1[19:17] == 3'd0) begin
        b.insn[15:0] = 16'h0;                      // Id 0, must be ignored
      end
    end else if (b.insn[31:16] == rv_trace_pkg::MARKER_HI) begin
      b.insn[16] = ~b.insn[16];
    end
    b.wben   = b.valid && (r1[5] | r1[6]);
    b.wbreg  = r1[20] ? rv_trace_pkg::SHADOW_REG : r1[25:21];
    b.wbdata = r2;
    return b;
  endfunction

  // Packet word order: dest, core, type, ts lo/hi, id, value lo/hi
  function automatic logic [15:0] flit_word(input stm_dbg_pkg::stm_stamped_t e,
                                            input int idx);
    case (idx)
      0:       return model_dest;
      1:       return CORE_ID;
      2:       return stm_dbg_pkg::STM_EVENT_TYPE;
      3:       return e.ts[15:0];
      4:       return e.ts[31:16];
      5:       return e.evt.id;
      6:       return e.evt.value[15:0];
      default: return e.evt.value[31:16];
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d  Errors: %0d  Packets: %0d", checks, errors, pkt_count);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic abort_timeout(input string what);
    errors++;
    $display("Timeout: %s", what);
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int t;
    t = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_i <= wdata;
    @(posedge clk);
    while (!wb_ack) begin                          // Held until ack
      if (t == TIMEOUT) begin
        abort_timeout("Wishbone slave never acknowledged the cycle");
      end
      t++;
      @(posedge clk);
    end
    rdata = wb_dat_o;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(posedge clk);
    check_eq("wb_ack", 32'(wb_ack), 32'd0);        // Ack lasts one cycle only
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'd0, data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Trace driver and model
  ////////////////////////////////////////////////////////////////////////////

  // Called right after a rising edge
  task automatic apply_beat(input rv_trace_pkg::rv_trace_t b);
    stm_dbg_pkg::stm_stamped_t e;
    logic                      timed;
    trace <= b;
    if (b.wben && (b.wbreg == rv_trace_pkg::SHADOW_REG)) begin
      model_x3 = b.wbdata;                         // Same beat marker sees it
    end
    if (b.valid && (b.insn[31:16] == rv_trace_pkg::MARKER_HI) &&
        (b.insn[15:0] != 16'h0) && model_en) begin
      if (room > 0) begin
        timed       = (exp_q.size() == 0);
        e.ts        = cyc_cnt + 32'd3;             // Queue entry edge
        e.evt.id    = b.insn[15:0];
        e.evt.value = model_x3;
        exp_q.push_back(e);
        exp_start.push_back(cyc_cnt + 32'd5);      // Flit 0 sampled here
        exp_timed.push_back(timed);
        room--;
      end else begin
        exp_drops++;
      end
    end
  endtask

  task automatic drive_beats(input int n);
    rv_trace_pkg::rv_trace_t b;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      trace_rnd = next_rand(trace_rnd);
      b         = make_beat(trace_rnd, next_rand(trace_rnd));
      trace_rnd = next_rand(trace_rnd);
      // Keep outstanding packets within capacity
      if ((b.insn[31:16] == rv_trace_pkg::MARKER_HI) &&
          (exp_q.size() >= int'(FIFO_DEPTH))) begin
        b.insn[24] = ~b.insn[24];
      end
      apply_beat(b);
    end
    @(posedge clk);
    apply_beat('0);                                // Idle trace
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
      if (t == TIMEOUT) begin
        abort_timeout("expected packets never left the DUT");
      end
      t++;
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    ready_rnd = next_rand(ready_rnd);
    case (ready_mode)
      2'd0:    debug_out_ready <= 1'b1;
      2'd1:    debug_out_ready <= ready_rnd[3] | ready_rnd[7];  // About 3 in 4
      default: debug_out_ready <= 1'b0;
    endcase
  end

  always @(posedge clk) begin : collect
    stm_dbg_pkg::stm_stamped_t e;
    if (arst_n) begin
      if (hold_chk) begin
        check_eq("debug_out stalled", 32'(debug_out), 32'(held));
      end
      hold_chk = 1'b0;
      if (debug_out.valid && debug_out_ready && debug_out.last) begin
        pkt_seen++;
      end
      if (debug_out.valid && (exp_q.size() == 0)) begin
        errors++;
        $display("Flit %h arrived with no packet expected", debug_out.data);
      end else if (debug_out.valid) begin
        e = exp_q[0];
        if ((flit_idx == 0) && !seen0) begin
          seen0 = 1'b1;
          if (exp_timed[0]) begin
            check_eq("flit 0 cycle", cyc_cnt, exp_start[0]);
          end
        end
        if (debug_out_ready) begin
          check_eq("debug_out.data", 32'(debug_out.data), 32'(flit_word(e, flit_idx)));
          check_eq("debug_out.last", 32'(debug_out.last),
                   32'(flit_idx == int'(stm_dbg_pkg::STM_PKT_FLITS) - 1));
          if (flit_idx == int'(stm_dbg_pkg::STM_PKT_FLITS) - 1) begin
            void'(exp_q.pop_front());
            void'(exp_start.pop_front());
            void'(exp_timed.pop_front());
            flit_idx = 0;
            seen0    = 1'b0;
            pkt_count++;
          end else begin
            flit_idx++;
          end
        end else begin
          held     = debug_out;                    // Must not move while stalled
          hold_chk = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rv_trace_pkg::rv_trace_t b;
    logic [31:0]             rd;
    int                      base;
    clk             = 1'b0;
    arst_n          = 1'b0;
    trace           = '0;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    wb_dat_i        = '0;
    debug_out_ready = 1'b0;
    trace_rnd       = SEED;
    ready_rnd       = SEED;
    model_x3        = '0;
    model_dest      = '0;
    model_en        = 1'b0;
    room            = NO_LIMIT;
    exp_drops       = 0;
    ready_mode      = 2'd0;
    errors          = 0;
    checks          = 0;
    pkt_count       = 0;
    pkt_seen        = 0;
    flit_idx        = 0;
    seen0           = 1'b0;
    hold_chk        = 1'b0;

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_eq("debug_out.valid after reset", 32'(debug_out.valid), 32'd0);
    check_eq("wb_ack after reset", 32'(wb_ack), 32'd0);

    // Disabled, markers must vanish
    wb_read(stm_dbg_pkg::REG_CTRL, rd);
    check_eq("REG_CTRL after reset", rd, 32'd0);
    wb_read(stm_dbg_pkg::REG_DEST, rd);
    check_eq("REG_DEST after reset", rd, 32'd0);
    drive_beats(60);
    repeat (8) @(posedge clk);
    check_eq("packets while disabled", 32'(pkt_seen), 32'd0);
    wb_read(stm_dbg_pkg::REG_DROPPED, rd);
    check_eq("REG_DROPPED while disabled", rd, 32'd0);
    wb_write(stm_dbg_pkg::REG_DEST, 32'h1234_a5c3);
    wb_read(stm_dbg_pkg::REG_DEST, rd);
    check_eq("REG_DEST", rd, 32'h0000_a5c3);
    model_dest = 16'ha5c3;
    wb_write(stm_dbg_pkg::REG_CTRL, 32'hffff_ffff);
    wb_read(stm_dbg_pkg::REG_CTRL, rd);
    check_eq("REG_CTRL", rd, 32'd1);
    model_en = 1'b1;

    // Ready high, marker with same-beat x3 write first
    @(posedge clk);
    b        = '0;
    b.valid  = 1'b1;
    b.insn   = {rv_trace_pkg::MARKER_HI, 16'h00a1};
    b.wben   = 1'b1;
    b.wbreg  = rv_trace_pkg::SHADOW_REG;
    b.wbdata = 32'hdead_beef;
    apply_beat(b);
    @(posedge clk);
    b.insn   = {rv_trace_pkg::MARKER_HI, 16'h0000};
    b.wbdata = 32'h0bad_f00d;
    apply_beat(b);
    drive_beats(200);
    wait_drain();

    // Random back-pressure
    ready_mode <= 2'd1;
    drive_beats(300);
    wait_drain();

    // Stalled output, burst overflows the queue
    ready_mode <= 2'd2;
    repeat (4) @(posedge clk);
    base      = pkt_seen;
    room      = int'(FIFO_DEPTH) + 1;
    exp_drops = 0;
    for (int i = 0; i < int'(FIFO_DEPTH) + 3; i++) begin
      @(posedge clk);
      trace_rnd   = next_rand(trace_rnd);
      b           = make_beat(trace_rnd, next_rand(trace_rnd));
      trace_rnd   = next_rand(trace_rnd);
      b.valid     = 1'b1;
      b.insn      = {rv_trace_pkg::MARKER_HI, 16'(i + 1)};
      apply_beat(b);
    end
    @(posedge clk);
    apply_beat('0);
    repeat (4) @(posedge clk);
    wb_read(stm_dbg_pkg::REG_LEVEL, rd);
    check_eq("REG_LEVEL", rd, 32'(FIFO_DEPTH));
    wb_read(stm_dbg_pkg::REG_DROPPED, rd);
    check_eq("REG_DROPPED", rd, 32'(exp_drops));
    room       = NO_LIMIT;
    ready_mode <= 2'd0;
    wait_drain();
    repeat (20) @(posedge clk);
    check_eq("packets after burst", 32'(pkt_seen - base), 32'(FIFO_DEPTH + 1));
    wb_write(stm_dbg_pkg::REG_DROPPED, 32'd0);
    wb_read(stm_dbg_pkg::REG_DROPPED, rd);
    check_eq("REG_DROPPED after clear", rd, 32'd0);

    finish_run();
  end

endmodule

`default_nettype wire

//--- hdl/stm_top.sv
`timescale 1ns/1ps
`default_nettype none

module stm_top #(
  parameter int unsigned FIFO_DEPTH = 4,
  parameter logic [15:0] CORE_ID    = 16'h0010
) (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire rv_trace_pkg::rv_trace_t trace,          // Core retirement beat
  // Register port
  input  wire logic                    wb_cyc,
  input  wire logic                    wb_stb,
  input  wire logic                    wb_we,
  input  wire logic [1:0]              wb_adr,
  input  wire logic [31:0]             wb_dat_i,
  output logic [31:0]                  wb_dat_o,
  output logic                         wb_ack,
  // Debug packet output
  output stm_dbg_pkg::dbg_flit_t       debug_out,
  input  wire logic                    debug_out_ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  stm_dbg_pkg::stm_event_t      evt;
  logic                         evt_valid;
  stm_dbg_pkg::stm_stamped_t    head;
  logic                         head_valid;
  logic                         pop;
  logic                         enable;
  logic [15:0]                  dest;
  logic [15:0]                  dropped;
  logic [$clog2(FIFO_DEPTH):0]  level;
  logic                         clear_dropped;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  stm_trace_tap u_tap (                     // Marker decode and x3 shadow
    .clk       (clk),
    .arst_n    (arst_n),
    .trace     (trace),
    .evt       (evt),
    .evt_valid (evt_valid)
  );

  stm_event_queue #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_queue (
    .clk           (clk),
    .arst_n        (arst_n),
    .enable        (enable),
    .evt           (evt),
    .evt_valid     (evt_valid),
    .head          (head),
    .head_valid    (head_valid),
    .pop           (pop),
    .dropped       (dropped),
    .level         (level),
    .clear_dropped (clear_dropped)
  );

  stm_pkt_builder #(
    .CORE_ID (CORE_ID)
  ) u_builder (
    .clk             (clk),
    .arst_n          (arst_n),
    .dest            (dest),
    .head            (head),
    .head_valid      (head_valid),
    .pop             (pop),
    .debug_out       (debug_out),
    .debug_out_ready (debug_out_ready)
  );

  // Control and status
  stm_ctrl_regs #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_regs (
    .clk           (clk),
    .arst_n        (arst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack        (wb_ack),
    .enable        (enable),
    .dest          (dest),
    .dropped       (dropped),
    .level         (level),
    .clear_dropped (clear_dropped)
  );

endmodule

`default_nettype wire

//--- hdl/stm_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module stm_ctrl_regs #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic                           clk,
  input  wire logic                           arst_n,
  // Wishbone classic slave
  input  wire logic                           wb_cyc,
  input  wire logic                           wb_stb,
  input  wire logic                           wb_we,
  input  wire logic [1:0]                     wb_adr,      // Word address
  input  wire logic [31:0]                    wb_dat_i,
  output logic [31:0]                         wb_dat_o,
  output logic                                wb_ack,
  // Control and status
  output logic                                enable,
  output logic [15:0]                         dest,
  input  wire logic [15:0]                    dropped,
  input  wire logic [$clog2(FIFO_DEPTH):0]    level,
  output logic                                clear_dropped
);

  logic        access;                      // New cycle, not yet acked
  logic        wr_en;
  logic [31:0] rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////////////////////////////////////////

  // Held ack blocks a second one while stb stays up
  assign access = wb_cyc && wb_stb && !wb_ack;
  assign wr_en  = access && wb_we;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;                     // Exactly one cycle
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable        <= 1'b0;
      dest          <= '0;
      clear_dropped <= 1'b0;
    end else begin
      clear_dropped <= wr_en && (wb_adr == stm_dbg_pkg::REG_DROPPED);  // Pulse
      if (wr_en && (wb_adr == stm_dbg_pkg::REG_CTRL)) begin
        enable <= wb_dat_i[0];
      end
      if (wr_en && (wb_adr == stm_dbg_pkg::REG_DEST)) begin
        dest <= wb_dat_i[15:0];
      end
    end
  end

  // Read mux, upper bits zero
  always_comb begin
    case (wb_adr)
      stm_dbg_pkg::REG_CTRL:    rd_data = {31'd0, enable};
      stm_dbg_pkg::REG_DEST:    rd_data = {16'd0, dest};
      stm_dbg_pkg::REG_DROPPED: rd_data = {16'd0, dropped};
      default:                  rd_data = 32'(level);  // REG_LEVEL
    endcase
  end

  // Read data lines up with ack
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_dat_o <= '0;
    end else if (access && !wb_we) begin
      wb_dat_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/stm_pkt_builder.sv
`timescale 1ns/1ps
`default_nettype none

module stm_pkt_builder #(
  parameter logic [15:0] CORE_ID = 16'h0010
) (
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic [15:0]               dest,            // Packet destination
  input  wire stm_dbg_pkg::stm_stamped_t head,
  input  wire logic                      head_valid,
  output logic                           pop,             // Take queue head
  output stm_dbg_pkg::dbg_flit_t         debug_out,
  input  wire logic                      debug_out_ready
);

  localparam int unsigned IW = stm_dbg_pkg::STM_IDX_W;
  localparam logic [IW-1:0] LAST_IDX = IW'(stm_dbg_pkg::STM_PKT_FLITS - 1);

  stm_dbg_pkg::stm_stamped_t ev_q;          // Event being sent
  logic [15:0]               dest_q;        // Destination frozen per packet
  logic                      busy;
  logic [IW-1:0]             idx;           // Current flit
  logic                      xfer;
  logic                      is_last;
  logic [15:0]               word;

  ////////////////////////////////////////////////////////////////////////////
  // Packet sequencing
  ////////////////////////////////////////////////////////////////////////////

  assign pop     = !busy && head_valid;     // Idle and work waiting
  assign xfer    = busy && debug_out_ready;
  assign is_last = (idx == LAST_IDX);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (pop) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (xfer) begin
      if (is_last) begin
        busy <= 1'b0;                       // Next pop on the following cycle
      end
      idx <= idx + 1'b1;                    // Wraps to 0 after the eighth
    end
  end

  // Event and destination held for the whole packet
  always_ff @(posedge clk) begin
    if (pop) begin
      ev_q   <= head;
      dest_q <= dest;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flit data
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (idx)
      3'd0:    word = dest_q;
      3'd1:    word = CORE_ID;
      3'd2:    word = stm_dbg_pkg::STM_EVENT_TYPE;
      3'd3:    word = ev_q.ts[15:0];
      3'd4:    word = ev_q.ts[31:16];
      3'd5:    word = ev_q.evt.id;
      3'd6:    word = ev_q.evt.value[15:0];
      default: word = ev_q.evt.value[31:16];
    endcase
  end

  // Data and last depend only on held state, stable while stalled
  assign debug_out.valid = busy;
  assign debug_out.last  = busy && is_last;
  assign debug_out.data  = word;

endmodule

`default_nettype wire

//--- hdl/stm_event_queue.sv
`timescale 1ns/1ps
`default_nettype none

module stm_event_queue #(
  parameter int unsigned FIFO_DEPTH = 4     // Power of two, at least 2
) (
  input  wire logic                          clk,
  input  wire logic                          arst_n,
  input  wire logic                          enable,        // Recording on
  input  wire stm_dbg_pkg::stm_event_t       evt,
  input  wire logic                          evt_valid,
  output stm_dbg_pkg::stm_stamped_t          head,          // Oldest entry
  output logic                               head_valid,
  input  wire logic                          pop,
  output logic [15:0]                        dropped,
  output logic [$clog2(FIFO_DEPTH):0]        level,
  input  wire logic                          clear_dropped
);

  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  stm_dbg_pkg::stm_stamped_t mem [FIFO_DEPTH];

  logic [31:0] ts_cnt;                      // Free-running cycle counter
  logic [AW:0] wr_ptr;                      // Extra bit tells full from empty
  logic [AW:0] rd_ptr;
  logic [AW:0] fill;
  logic        full;
  logic        push_req;
  logic        push;
  logic        drop;
  logic        do_pop;

  ////////////////////////////////////////////////////////////////////////////
  // Timestamp
  ////////////////////////////////////////////////////////////////////////////

  // Reads 0 at the first edge after reset, then wraps
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ts_cnt <= '0;
    end else begin
      ts_cnt <= ts_cnt + 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////////////////////////////////////////

  assign fill       = wr_ptr - rd_ptr;
  assign full       = (fill == (AW+1)'(FIFO_DEPTH));
  assign head_valid = (fill != '0);
  assign level      = fill;

  assign do_pop   = pop && head_valid;
  assign push_req = evt_valid && enable;    // Disabled events just vanish
  assign push     = push_req && (!full || do_pop);  // Slot freed this edge
  assign drop     = push_req && !push;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage, stamped on entry
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= '{ts: ts_cnt, evt: evt};
    end
  end

  assign head = mem[rd_ptr[AW-1:0]];

  ////////////////////////////////////////////////////////////////////////////
  // Drop counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dropped <= '0;
    end else if (clear_dropped) begin
      dropped <= '0;                        // Clear beats a same-cycle drop
    end else if (drop && (dropped != '1)) begin
      dropped <= dropped + 16'd1;           // Saturates at all ones
    end
  end

endmodule

`default_nettype wire

//--- hdl/stm_trace_tap.sv
`timescale 1ns/1ps
`default_nettype none

module stm_trace_tap (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire rv_trace_pkg::rv_trace_t trace,     // Retirement beat from core
  output stm_dbg_pkg::stm_event_t      evt,
  output logic                         evt_valid  // One cycle per marker
);

  rv_trace_pkg::rv_trace_t beat_q;                 // Sampled trace beat
  logic [31:0]             shadow_x3;
  logic                    x3_write;
  logic                    is_marker;

  ////////////////////////////////////////////////////////////////////////////
  // Input stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_q <= '0;
    end else begin
      beat_q <= trace;                             // Registered for timing
    end
  end

  // Decode on the sampled beat
  assign x3_write  = beat_q.wben && (beat_q.wbreg == rv_trace_pkg::SHADOW_REG);
  assign is_marker = beat_q.valid &&
                     (beat_q.insn[31:16] == rv_trace_pkg::MARKER_HI) &&
                     (beat_q.insn[15:0] != 16'h0);  // Id 0 is not an event

  ////////////////////////////////////////////////////////////////////////////
  // x3 shadow and event register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shadow_x3 <= '0;
    end else if (x3_write) begin
      shadow_x3 <= beat_q.wbdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      evt_valid <= 1'b0;
    end else begin
      evt_valid <= is_marker;
    end
  end

  // Payload only loads on a marker
  always_ff @(posedge clk) begin
    if (is_marker) begin
      evt.id    <= beat_q.insn[15:0];
      // Same-beat x3 write wins over the old shadow
      evt.value <= x3_write ? beat_q.wbdata : shadow_x3;
    end
  end

endmodule

`default_nettype wire

//--- hdl/stm_dbg_pkg.sv
`default_nettype none

package stm_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Debug interconnect flit
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        valid;                  // Flit present on the link
    logic        last;                   // Final flit of a packet
    logic [15:0] data;
  } dbg_flit_t;

  ////////////////////////////////////////////////////////////////////////////
  // Trace events
  ////////////////////////////////////////////////////////////////////////////

  // Raw event from the marker decoder
  typedef struct packed {
    logic [15:0] id;                     // Lower half of the marker
    logic [31:0] value;                  // x3 contents at the marker
  } stm_event_t;

  // Event as held in the queue
  typedef struct packed {
    logic [31:0] ts;                     // Cycle count at queue entry
    stm_event_t  evt;
  } stm_stamped_t;

  // Packet layout
  localparam int unsigned STM_PKT_FLITS  = 8;
  localparam int unsigned STM_IDX_W      = $clog2(STM_PKT_FLITS);
  localparam logic [15:0] STM_EVENT_TYPE = 16'h4000;

  // Register map, word addresses
  localparam logic [1:0] REG_CTRL    = 2'd0;
  localparam logic [1:0] REG_DEST    = 2'd1;
  localparam logic [1:0] REG_DROPPED = 2'd2;
  localparam logic [1:0] REG_LEVEL   = 2'd3;

endpackage

`default_nettype wire

//--- hdl/rv_trace_pkg.sv
`default_nettype none

package rv_trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Core retirement trace
  ////////////////////////////////////////////////////////////////////////////

  // One beat per cycle from the core
  typedef struct packed {
    logic        valid;                  // Instruction retired this cycle
    logic [31:0] insn;                   // Retired instruction word
    logic        wben;                   // Register write-back this cycle
    logic [4:0]  wbreg;                  // Destination register
    logic [31:0] wbdata;                 // Value written
  } rv_trace_t;

  ////////////////////////////////////////////////////////////////////////////
  // Software marker encoding
  ////////////////////////////////////////////////////////////////////////////

  // Upper half of a marker instruction
  localparam logic [15:0] MARKER_HI = 16'h1500;

  // Register whose last value goes with each event
  localparam logic [4:0] SHADOW_REG = 5'd3;

endpackage

`default_nettype wire
